// File: sim.f
verilog/cache_pkg.sv
verilog/cache_sram_if.sv
verilog/cache_data_sram.sv
verilog/cache_ctrl.sv
verilog/cache_top.sv
tb/cache_properties.sv
tb/cache_tb.sv

// File: tb/cache_properties.sv
`timescale 1ns/1ps

module cache_properties
    import cache_pkg::*;
(
    input logic         clk,
    input logic         rst,
    input logic         rd_req,
    input logic         rd_ready,
    input logic         rd_last,
    input logic         wr_req,
    input logic         fence,
    input logic         ready,
    input cache_state_e state
);

    int fail_count = 0;

    // one bus direction at a time
    a_one_req: assert property (@(posedge clk) disable iff (rst) !(rd_req && wr_req))
        else begin
            fail_count++;
            $error("rd_req and wr_req are high in the same cycle");
        end

    // a read burst only ends on its last beat
    a_rd_hold: assert property (@(posedge clk) disable iff (rst)
        rd_req && !(rd_ready && rd_last) |=> rd_req)
        else begin
            fail_count++;
            $error("rd_req dropped before the last beat");
        end

    // a fence taken in idle starts the walk
    a_fence_walk: assert property (@(posedge clk) disable iff (rst)
        (state == ST_IDLE) && fence |=> !ready)
        else begin
            fail_count++;
            $error("ready stayed high after a fence was accepted in idle");
        end

endmodule

bind cache_ctrl cache_properties props_i (
    .clk      (clk),
    .rst      (rst),
    .rd_req   (rd_req),
    .rd_ready (rd_ready),
    .rd_last  (rd_last),
    .wr_req   (wr_req),
    .fence    (fence),
    .ready    (ready),
    .state    (state)
);

// File: tb/cache_tb.sv
`timescale 1ns/1ps

module cache_tb
    import cache_pkg::*;
();

    localparam int TAG_BITS   = 21;
    localparam int INDEX_BITS = 5;
    localparam logic [31:0] SEED = 32'hb90985f0;
    localparam int N_CACHED   = 400;
    localparam int N_UNCACHED = 60;
    localparam int N_AFTER    = 150;
    // writeback plus eight refill beats, each stalled at random
    localparam int OP_CYCLES  = 150;
    localparam int LIMIT = (N_CACHED + N_UNCACHED + N_AFTER) * OP_CYCLES + 64 * 40 + 100;

    logic                   clk;
    logic                   rst;
    logic                   valid;
    logic                   op;
    logic                   taken;
    logic                   fence;
    logic [TAG_BITS-1:0]    tag;
    logic [INDEX_BITS-1:0]  index;
    logic [OFFSET_BITS-1:0] offset;
    strb_t                  wstrb;
    word_t                  wdata;
    logic                   ok;
    logic                   ready;
    word_t                  rdata;
    logic                   rw_error;
    bus_addr_t              addr;
    logic                   rd_req;
    logic                   rd_ready;
    logic                   rd_error;
    logic                   rd_last;
    word_t                  rd_data;
    logic                   wr_req;
    line_t                  wr_data;
    logic                   wr_ready;
    logic                   wr_error;

    // word addressed, keyed by addr[31:3]
    word_t       mem [logic [28:0]];
    word_t       ref_mem [logic [28:0]];
    logic [31:0] stim_lfsr;
    logic [31:0] bus_lfsr;
    logic [2:0]  beat;
    logic        last_rd_err;
    logic        last_wr_err;
    int          cycles = 0;
    string       cur_test;
    int          test_checks;
    int          test_errors;
    int          total_checks;
    int          total_errors;
    int          assert_fails;

    cache_top #(
        .TAG_BITS   (TAG_BITS),
        .INDEX_BITS (INDEX_BITS)
    ) cache_top_i (
        .clk      (clk),
        .rst      (rst),
        .valid    (valid),
        .op       (op),
        .taken    (taken),
        .fence    (fence),
        .tag      (tag),
        .index    (index),
        .offset   (offset),
        .wstrb    (wstrb),
        .wdata    (wdata),
        .ok       (ok),
        .ready    (ready),
        .rdata    (rdata),
        .rw_error (rw_error),
        .addr     (addr),
        .rd_req   (rd_req),
        .rd_ready (rd_ready),
        .rd_error (rd_error),
        .rd_last  (rd_last),
        .rd_data  (rd_data),
        .wr_req   (wr_req),
        .wr_data  (wr_data),
        .wr_ready (wr_ready),
        .wr_error (wr_error)
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] galois_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    function automatic logic [31:0] take_bits(inout logic [31:0] state, input int n);
        logic [31:0] r;
        r = '0;
        for (int k = 0; k < n; k++) begin
            state = galois_step(state);
            r = {r[30:0], state[0]};
        end
        return r;
    endfunction

    // untouched memory pattern from the full word address
    function automatic word_t init_word(input logic [28:0] wa);
        return {3'b101, wa, ~wa, 3'b010};
    endfunction

    function automatic word_t mem_word(input logic [28:0] wa);
        return mem.exists(wa) ? mem[wa] : init_word(wa);
    endfunction

    function automatic word_t ref_word(input logic [28:0] wa);
        return ref_mem.exists(wa) ? ref_mem[wa] : init_word(wa);
    endfunction

    function automatic word_t merge_bytes(input word_t old, input word_t d, input strb_t s);
        word_t r;
        r = old;
        for (int j = 0; j < $bits(strb_t); j++) begin
            if (s[j]) begin
                r[j*8 +: 8] = d[j*8 +: 8];
            end
        end
        return r;
    endfunction

    task automatic note_mismatch(input string what, input word_t exp, input word_t act);
        test_errors++;
        $display("mismatch %s %s: expected %h actual %h", cur_test, what, exp, act);
    endtask

    task automatic finish_test();
        $display("%s: %0d checks, %0d errors", cur_test, test_checks, test_errors);
        total_checks += test_checks;
        total_errors += test_errors;
        test_checks = 0;
        test_errors = 0;
    endtask

    task automatic run_access(input logic unc);
        logic        o;
        logic [20:0] t;
        logic [4:0]  i;
        logic [2:0]  f;
        strb_t       s;
        word_t       d;
        logic [28:0] wa;
        word_t       exp;
        // few tags over few sets so ways collide
        if (unc) begin
            t = {1'b0, 19'h0, 1'(take_bits(stim_lfsr, 1))};
        end else begin
            t = {1'b1, 18'h0, 2'(take_bits(stim_lfsr, 2))};
        end
        i = 5'(take_bits(stim_lfsr, 3));
        f = 3'(take_bits(stim_lfsr, 3));
        o = 1'(take_bits(stim_lfsr, 1));
        s = 8'(take_bits(stim_lfsr, 8));
        d[63:32] = take_bits(stim_lfsr, 32);
        d[31:0] = take_bits(stim_lfsr, 32);
        wa = {t, i, f};
        @(posedge clk);
        valid  <= 1'b1;
        op     <= o;
        tag    <= t;
        index  <= i;
        offset <= f;
        wstrb  <= s;
        wdata  <= d;
        @(negedge clk);
        while (!ok) begin
            @(negedge clk);
        end
        exp = unc ? mem_word(wa) : ref_word(wa);
        if (o) begin
            ref_mem[wa] = merge_bytes(ref_word(wa), d, s);
        end
        if (unc) begin
            test_checks++;
            if (rw_error !== (o ? last_wr_err : last_rd_err)) begin
                note_mismatch("rw_error", word_t'(o ? last_wr_err : last_rd_err), word_t'(rw_error));
            end
            if (!o) begin
                test_checks++;
                if (rdata !== exp) begin
                    note_mismatch("uncached read", exp, rdata);
                end
            end
        end
        @(posedge clk);
        valid <= 1'b0;
        taken <= unc;
        if (!o && !unc) begin
            // read data follows the ok cycle
            @(negedge clk);
            test_checks++;
            if (rdata !== exp) begin
                note_mismatch("cached read", exp, rdata);
            end
        end
        if (unc) begin
            @(posedge clk);
            taken <= 1'b0;
        end
    endtask

    task automatic run_fence();
        @(posedge clk);
        fence <= 1'b1;
        @(posedge clk);
        fence <= 1'b0;
        @(negedge clk);
        test_checks++;
        if (ready !== 1'b0) begin
            note_mismatch("ready during walk", '0, word_t'(ready));
        end
        while (!ready) begin
            @(negedge clk);
        end
        foreach (ref_mem[k]) begin
            test_checks++;
            if (mem_word(k) !== ref_mem[k]) begin
                note_mismatch("memory after fence", ref_mem[k], mem_word(k));
            end
        end
    endtask

    // memory side of the bus, decided from last cycle's levels
    always @(posedge clk) begin : bus_model
        logic [2:0]  nbeat;
        logic [28:0] wa;
        logic [31:0] r;
        word_t       exp;
        word_t       act;
        if (rst) begin
            beat = '0;
            rd_ready <= 1'b0;
            rd_last  <= 1'b0;
            rd_error <= 1'b0;
            wr_ready <= 1'b0;
            wr_error <= 1'b0;
        end else begin
            if (rd_req && rd_ready && !addr[31]) begin
                last_rd_err = rd_error;
            end
            nbeat = beat;
            if (rd_req && rd_ready) begin
                nbeat = rd_last ? 3'd0 : beat + 3'd1;
            end
            beat = nbeat;
            if (rd_req && !(rd_ready && rd_last)) begin
                r = take_bits(bus_lfsr, 4);
                wa = addr[31:3] + 29'(nbeat);
                rd_ready <= (r[1:0] != 2'b00);
                rd_data  <= mem_word(wa);
                rd_last  <= !addr[31] || (nbeat == 3'd7);
                rd_error <= !addr[31] && (r[3:2] == 2'b00);
            end else begin
                rd_ready <= 1'b0;
                rd_last  <= 1'b0;
                rd_error <= 1'b0;
            end
            if (wr_req && wr_ready) begin
                wa = addr[31:3];
                if (!addr[31]) begin
                    last_wr_err = wr_error;
                    exp = merge_bytes('0, wdata, wstrb);
                    act = merge_bytes('0, wr_data[63:0], wstrb);
                    test_checks++;
                    if (act !== exp) begin
                        note_mismatch("uncached write data", exp, act);
                    end
                    mem[wa] = merge_bytes(mem_word(wa), wr_data[63:0], wstrb);
                end else begin
                    for (int w = 0; w < LINE_BEATS; w++) begin
                        exp = ref_word(wa + 29'(w));
                        act = wr_data[w*WORD_BITS +: WORD_BITS];
                        test_checks++;
                        if (act !== exp) begin
                            note_mismatch("writeback word", exp, act);
                        end
                        mem[wa + 29'(w)] = act;
                    end
                end
            end
            r = take_bits(bus_lfsr, 4);
            wr_ready <= (r[1:0] != 2'b00);
            wr_error <= (r[3:2] == 2'b00);
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", LIMIT);
            $display("Test FAILED");
            $finish;
        end
    end

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        valid = 1'b0;
        op = 1'b0;
        taken = 1'b0;
        fence = 1'b0;
        tag = '0;
        index = '0;
        offset = '0;
        wstrb = '0;
        wdata = '0;
        rd_ready = 1'b0;
        rd_error = 1'b0;
        rd_last = 1'b0;
        rd_data = '0;
        wr_ready = 1'b0;
        wr_error = 1'b0;
        beat = '0;
        last_rd_err = 1'b0;
        last_wr_err = 1'b0;
        stim_lfsr = SEED;
        bus_lfsr = SEED;
        test_checks = 0;
        test_errors = 0;
        total_checks = 0;
        total_errors = 0;
        cur_test = "reset";
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        test_checks += 3;
        if (rd_req !== 1'b0) begin
            note_mismatch("rd_req", '0, word_t'(rd_req));
        end
        if (wr_req !== 1'b0) begin
            note_mismatch("wr_req", '0, word_t'(wr_req));
        end
        if (ready !== 1'b1) begin
            note_mismatch("ready", word_t'(1), word_t'(ready));
        end
        finish_test();

        cur_test = "cached";
        repeat (N_CACHED) run_access(1'b0);
        finish_test();

        cur_test = "uncached";
        repeat (N_UNCACHED) run_access(1'b1);
        finish_test();

        cur_test = "fence";
        run_fence();
        finish_test();

        cur_test = "after_fence";
        repeat (N_AFTER) run_access(1'b0);
        finish_test();

        assert_fails = cache_top_i.cache_ctrl_i.props_i.fail_count;
        $display("total: %0d checks, %0d errors, %0d assertion failures",
                 total_checks, total_errors, assert_fails);
        if (total_errors == 0 && assert_fails == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// File: verilog/cache_ctrl.sv
`timescale 1ns/1ps

module cache_ctrl
    import cache_pkg::*;
#(
    parameter int TAG_BITS   = 21,
    parameter int INDEX_BITS = 5
) (
    input  logic                   clk,
    input  logic                   rst,
    // cpu side
    input  logic                   valid,
    input  logic                   op,
    input  logic                   taken,
    input  logic                   fence,
    input  logic [TAG_BITS-1:0]    tag,
    input  logic [INDEX_BITS-1:0]  index,
    input  logic [OFFSET_BITS-1:0] offset,
    input  strb_t                  wstrb,
    input  word_t                  wdata,
    output logic                   ok,
    output logic                   ready,
    output word_t                  rdata,
    output logic                   rw_error,
    // bus side
    output bus_addr_t              addr,
    output logic                   rd_req,
    input  logic                   rd_ready,
    input  logic                   rd_error,
    input  logic                   rd_last,
    input  word_t                  rd_data,
    output logic                   wr_req,
    output line_t                  wr_data,
    input  logic                   wr_ready,
    input  logic                   wr_error,
    // data sram
    cache_sram_if.ctrl             sram
);

    localparam int SETS = 1 << INDEX_BITS;
    localparam int ROWS = 2 * SETS;

    typedef logic [TAG_BITS-1:0] tag_t;
    typedef logic [INDEX_BITS:0] row_t;

    tag_t             tag_mem [ROWS];
    logic [ROWS-1:0]  line_valid;
    logic [ROWS-1:0]  line_dirty;
    // way used most recently, per set
    logic [SETS-1:0]  mru;

    cache_state_e     state;
    row_t             walk_row;
    logic [OFFSET_BITS-1:0] beat_cnt;
    logic             victim_q;
    logic             unc_act;
    logic             unc_done;
    logic             sel_unc;
    logic [OFFSET_BITS-1:0] offset_q;
    word_t            unc_data;

    row_t             row0;
    row_t             row1;
    row_t             row;
    line_t            line_q;
    line_t            wmask;
    word_t            fill_word;
    logic             idle;
    logic             uncache;
    logic             hit_0;
    logic             hit_1;
    logic             way_hit;
    logic             hit;
    logic             miss;
    logic             unc_start;
    logic             victim;
    logic             victim_dirty;
    logic             rd_fire;
    logic             wr_fire;
    logic             refill_fire;
    logic             walk_dirty;
    logic             walk_adv;

    function automatic bus_addr_t line_addr(tag_t t, logic [INDEX_BITS-1:0] i);
        return bus_addr_t'({t, i, {LINE_BYTE_BITS{1'b0}}});
    endfunction

    assign idle    = (state == ST_IDLE);
    // top tag bit clear means device space
    assign uncache = valid && !tag[TAG_BITS-1];

    assign row0    = {index, 1'b0};
    assign row1    = {index, 1'b1};
    assign hit_0   = line_valid[row0] && (tag_mem[row0] == tag);
    assign hit_1   = line_valid[row1] && (tag_mem[row1] == tag);
    assign way_hit = hit_0 || hit_1;

    // fence wins over a new miss in the same cycle
    assign hit       = idle && valid && !uncache && way_hit;
    assign miss      = idle && !fence && valid && !uncache && !way_hit;
    assign unc_start = idle && !fence && uncache && !unc_done;

    // invalid way, then the clean one, then not most recent
    assign victim = (!line_valid[row0] || !line_valid[row1]) ? line_valid[row0] :
                    (line_dirty[row0] ^ line_dirty[row1])    ? line_dirty[row0] :
                                                               !mru[index];
    assign victim_dirty = line_valid[{index, victim}] && line_dirty[{index, victim}];

    assign rd_fire     = rd_req && rd_ready;
    assign wr_fire     = wr_req && wr_ready;
    assign refill_fire = (state == ST_REFILL) && rd_fire && !unc_act;
    assign walk_dirty  = line_valid[walk_row] && line_dirty[walk_row];
    assign walk_adv    = (state == ST_FLUSH) && (wr_req ? wr_ready : !walk_dirty);

    assign ok    = uncache ? unc_done : hit;
    assign ready = (state != ST_FLUSH);

    always_comb begin
        if (state == ST_FLUSH) begin
            row = walk_row;
        end else if (!idle) begin
            row = {index, victim_q};
        end else begin
            row = {index, way_hit ? hit_1 : victim};
        end
    end

    assign sram.a    = sram_addr_t'(row);
    assign sram.wen  = !(refill_fire || (hit && op));
    assign fill_word = refill_fire ? rd_data : wdata;

    // whole beat slot on refill, strobed bytes on a write hit
    always_comb begin
        for (int w = 0; w < LINE_BEATS; w++) begin
            for (int j = 0; j < $bits(strb_t); j++) begin
                if (refill_fire) begin
                    wmask[w*WORD_BITS + j*8 +: 8] = {8{beat_cnt == OFFSET_BITS'(w)}};
                end else begin
                    wmask[w*WORD_BITS + j*8 +: 8] = {8{(offset == OFFSET_BITS'(w)) && wstrb[j]}};
                end
            end
        end
    end

    assign sram.bwen = ~wmask;

    for (genvar b = 0; b < SRAM_BANKS; b++) begin : g_bank
        assign sram.d[b] = {BANK_WORDS{fill_word}};
        assign line_q[b*$bits(bank_t) +: $bits(bank_t)] = sram.q[b];
    end

    assign rdata   = sel_unc ? unc_data : line_q[offset_q*WORD_BITS +: WORD_BITS];
    assign wr_data = unc_act ? {line_q[$bits(line_t)-1:WORD_BITS], wdata} : line_q;

    always_ff @(posedge clk) begin
        if (refill_fire && rd_last) begin
            tag_mem[{index, victim_q}] <= tag;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            line_valid <= '0;
            line_dirty <= '0;
            mru        <= '0;
        end else begin
            if (hit) begin
                mru[index] <= hit_1;
                if (op) begin
                    line_dirty[{index, hit_1}] <= 1'b1;
                end
            end
            if (refill_fire && rd_last) begin
                line_valid[{index, victim_q}] <= 1'b1;
                line_dirty[{index, victim_q}] <= 1'b0;
            end
            if ((state == ST_WRITEBACK) && wr_fire && !unc_act) begin
                line_dirty[{index, victim_q}] <= 1'b0;
            end
            if ((state == ST_FLUSH) && wr_fire) begin
                line_dirty[walk_row] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= ST_IDLE;
            rd_req   <= 1'b0;
            wr_req   <= 1'b0;
            unc_act  <= 1'b0;
            unc_done <= 1'b0;
            rw_error <= 1'b0;
            walk_row <= '0;
            beat_cnt <= '0;
        end else begin
            if (taken) begin
                unc_done <= 1'b0;
            end
            case (state)
                ST_IDLE: begin
                    beat_cnt <= '0;
                    unc_act  <= unc_start;
                    if (fence) begin
                        state    <= ST_FLUSH;
                        walk_row <= '0;
                    end else if (unc_start) begin
                        state  <= op ? ST_WRITEBACK : ST_REFILL;
                        wr_req <= op;
                        rd_req <= !op;
                    end else if (miss) begin
                        state  <= victim_dirty ? ST_WRITEBACK : ST_REFILL;
                        wr_req <= victim_dirty;
                        rd_req <= !victim_dirty;
                    end
                end
                ST_REFILL: begin
                    if (rd_fire) begin
                        beat_cnt <= beat_cnt + 1'b1;
                        if (rd_last) begin
                            rd_req <= 1'b0;
                            state  <= ST_IDLE;
                            if (unc_act) begin
                                unc_done <= 1'b1;
                                rw_error <= rd_error;
                            end
                        end
                    end
                end
                ST_WRITEBACK: begin
                    if (wr_fire) begin
                        wr_req <= 1'b0;
                        if (unc_act) begin
                            state    <= ST_IDLE;
                            unc_done <= 1'b1;
                            rw_error <= wr_error;
                        end else begin
                            // victim is out, fetch the new line
                            state  <= ST_REFILL;
                            rd_req <= 1'b1;
                        end
                    end
                end
                ST_FLUSH: begin
                    if (!wr_req && walk_dirty) begin
                        wr_req <= 1'b1;
                    end
                    if (wr_fire) begin
                        wr_req <= 1'b0;
                    end
                    if (walk_adv) begin
                        walk_row <= walk_row + 1'b1;
                        if (&walk_row) begin
                            state <= ST_IDLE;
                        end
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (unc_start) begin
            addr <= bus_addr_t'({tag, index, offset, {BYTE_BITS{1'b0}}});
        end else if (miss) begin
            addr <= victim_dirty ? line_addr(tag_mem[{index, victim}], index)
                                 : line_addr(tag, index);
        end else if ((state == ST_WRITEBACK) && wr_fire && !unc_act) begin
            addr <= line_addr(tag, index);
        end else if ((state == ST_FLUSH) && !wr_req) begin
            addr <= line_addr(tag_mem[walk_row], walk_row[INDEX_BITS:1]);
        end
    end

    // payload for the word returned to the cpu
    always_ff @(posedge clk) begin
        offset_q <= offset;
        sel_unc  <= uncache;
        if (miss) begin
            victim_q <= victim;
        end
        if ((state == ST_REFILL) && rd_fire && unc_act) begin
            unc_data <= rd_data;
        end
    end

endmodule

// File: verilog/cache_data_sram.sv
`timescale 1ns/1ps

module cache_data_sram
    import cache_pkg::*;
(
    input logic       clk,
    cache_sram_if.mem mem
);

    localparam int DEPTH     = 1 << $bits(sram_addr_t);
    localparam int BANK_BITS = $bits(bank_t);

    // bank b covers line words 2b and 2b+1
    for (genvar b = 0; b < SRAM_BANKS; b++) begin : g_bank
        bank_t ram [DEPTH];

        always_ff @(posedge clk) begin
            for (int i = 0; i < BANK_BITS; i++) begin
                if (!mem.wen && !mem.bwen[b*BANK_BITS + i]) begin
                    ram[mem.a][i] <= mem.d[b][i];
                end
            end
            // read before write on the same row
            mem.q[b] <= ram[mem.a];
        end
    end

endmodule

// File: verilog/cache_pkg.sv
package cache_pkg;

    // word, line and bus geometry
    localparam int WORD_BITS      = 64;
    localparam int BYTE_BITS      = 3;
    localparam int OFFSET_BITS    = 3;
    localparam int LINE_BEATS     = 1 << OFFSET_BITS;
    localparam int LINE_BYTE_BITS = OFFSET_BITS + BYTE_BITS;
    localparam int PADDR_BITS     = 32;

    // data sram organisation, two line words per bank
    localparam int SRAM_BANKS = 4;
    localparam int BANK_WORDS = LINE_BEATS / SRAM_BANKS;

    typedef logic [WORD_BITS-1:0]            word_t;
    typedef logic [LINE_BEATS*WORD_BITS-1:0] line_t;
    typedef logic [BANK_WORDS*WORD_BITS-1:0] bank_t;
    typedef logic [PADDR_BITS-1:0]           bus_addr_t;
    typedef logic [WORD_BITS/8-1:0]          strb_t;
    // set index with the way as lsb
    typedef logic [5:0]                      sram_addr_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_REFILL,
        ST_WRITEBACK,
        ST_FLUSH
    } cache_state_e;

endpackage

// File: verilog/cache_sram_if.sv
`timescale 1ns/1ps

interface cache_sram_if
    import cache_pkg::*;
();

    sram_addr_t a;
    bank_t      d [SRAM_BANKS];
    bank_t      q [SRAM_BANKS];
    // both enables active low
    logic       wen;
    line_t      bwen;

    modport ctrl (
        output a,
        output d,
        output wen,
        output bwen,
        input  q
    );

    modport mem (
        input  a,
        input  d,
        input  wen,
        input  bwen,
        output q
    );

endinterface

// File: verilog/cache_top.sv
`timescale 1ns/1ps

module cache_top
    import cache_pkg::*;
#(
    parameter int TAG_BITS   = 21,
    parameter int INDEX_BITS = 5
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   valid,
    input  logic                   op,
    input  logic                   taken,
    input  logic                   fence,
    input  logic [TAG_BITS-1:0]    tag,
    input  logic [INDEX_BITS-1:0]  index,
    input  logic [OFFSET_BITS-1:0] offset,
    input  strb_t                  wstrb,
    input  word_t                  wdata,
    output logic                   ok,
    output logic                   ready,
    output word_t                  rdata,
    output logic                   rw_error,
    output bus_addr_t              addr,
    output logic                   rd_req,
    input  logic                   rd_ready,
    input  logic                   rd_error,
    input  logic                   rd_last,
    input  word_t                  rd_data,
    output logic                   wr_req,
    output line_t                  wr_data,
    input  logic                   wr_ready,
    input  logic                   wr_error
);

    cache_sram_if sram_bus ();

    cache_ctrl #(
        .TAG_BITS   (TAG_BITS),
        .INDEX_BITS (INDEX_BITS)
    ) cache_ctrl_i (
        .clk      (clk),
        .rst      (rst),
        .valid    (valid),
        .op       (op),
        .taken    (taken),
        .fence    (fence),
        .tag      (tag),
        .index    (index),
        .offset   (offset),
        .wstrb    (wstrb),
        .wdata    (wdata),
        .ok       (ok),
        .ready    (ready),
        .rdata    (rdata),
        .rw_error (rw_error),
        .addr     (addr),
        .rd_req   (rd_req),
        .rd_ready (rd_ready),
        .rd_error (rd_error),
        .rd_last  (rd_last),
        .rd_data  (rd_data),
        .wr_req   (wr_req),
        .wr_data  (wr_data),
        .wr_ready (wr_ready),
        .wr_error (wr_error),
        .sram     (sram_bus.ctrl)
    );

    cache_data_sram cache_data_sram_i (
        .clk (clk),
        .mem (sram_bus.mem)
    );

endmodule
